/* all.f */
rtl/ft245_pkg.sv
rtl/ft_cycle_if.sv
rtl/ft245_bus_ctrl.sv
rtl/ft245_read_engine.sv
rtl/ft245_write_engine.sv
rtl/ft245_rx_port.sv
rtl/ft245_tx_port.sv
rtl/ft245_bridge.sv
dv/ft245_bridge_assertions.sv
dv/ft245_bridge_tb.sv

/* dv/ft245_bridge_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ft245_bridge_assertions (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     o_ft_rd_n,
    input  logic                     o_ft_wr_n,
    input  logic                     o_ft_data_oe,
    input  logic                     o_rx_req,
    input  ft245_pkg::ft_byte_t      o_rx_data,
    input  ft245_pkg::ft_arb_state_e i_arb_state
);
    import ft245_pkg::*;

    int fail_count = 0;

    // The bus carries only one cycle at a time
    a_rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(!o_ft_rd_n && !o_ft_wr_n))
        else begin
            $error("RD# and WR# are low together");
            fail_count++;
        end

    a_oe_during_wr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_ft_wr_n |-> o_ft_data_oe)
        else begin
            $error("Output enable is low during the WR# pulse");
            fail_count++;
        end

    // The chip drives the bus while RD# is low
    a_no_oe_during_rd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_ft_rd_n |-> !o_ft_data_oe)
        else begin
            $error("Output enable is high during the RD# pulse");
            fail_count++;
        end

    a_rd_owned_by_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_ft_rd_n |-> i_arb_state == ARB_READ)
        else begin
            $error("RD# is low outside the arbiter READ state");
            fail_count++;
        end

    a_rx_data_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rx_req && $past(o_rx_req) |-> $stable(o_rx_data))
        else begin
            $error("o_rx_data changed while o_rx_req was high");
            fail_count++;
        end

endmodule

bind ft245_bridge ft245_bridge_assertions u_assertions (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .o_ft_rd_n    (o_ft_rd_n),
    .o_ft_wr_n    (o_ft_wr_n),
    .o_ft_data_oe (o_ft_data_oe),
    .o_rx_req     (o_rx_req),
    .o_rx_data    (o_rx_data),
    .i_arb_state  (u_bus_ctrl.state)
);

`default_nettype wire

/* dv/ft245_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ft245_bridge_tb;
    import ft245_pkg::*;

    localparam int          P_PULSE         = FT_PULSE_DEFAULT;
    localparam logic [31:0] SEED            = 32'h221e4b06;
    localparam int          TX_BASE         = 512;
    localparam int          TOTAL_BYTES     = 64 + 64 + 4 + 2 + 64 + 64;
    localparam int          WATCHDOG_CYCLES = TOTAL_BYTES * 40 * (P_PULSE + 6);

    logic     clk;
    logic     rst_n;
    ft_byte_t ft_data_in;
    ft_byte_t ft_data_out;
    logic     ft_data_oe;
    logic     ft_rxf_n;
    logic     ft_txe_n;
    logic     ft_rd_n;
    logic     ft_wr_n;
    logic     rx_req;
    ft_byte_t rx_data;
    logic     rx_ack;
    logic     tx_req;
    ft_byte_t tx_data;
    logic     tx_ack;

    ft_byte_t    host_q[$];
    int          rx_pushed = 0;
    int          rx_count = 0;
    int          tx_sent = 0;
    int          wr_count = 0;
    int          rd_pulses = 0;
    int          wr_pulses = 0;
    int          dir_switches = 0;
    logic        last_dir = 1'b0;
    int          rd_len = 0;
    int          wr_len = 0;
    logic        rd_was_low = 1'b0;
    logic        rx_hold = 1'b0;
    logic        txe_hold_high = 1'b0;
    logic [31:0] tx_rnd = SEED ^ 32'h1;
    int          byte_errors = 0;
    int          pulse_errors = 0;
    int          level_errors = 0;
    int          other_errors = 0;

    ft245_bridge #(
        .P_PULSE_CYCLES (P_PULSE)
    ) u_dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_ft_data    (ft_data_in),
        .o_ft_data    (ft_data_out),
        .o_ft_data_oe (ft_data_oe),
        .i_ft_rxf_n   (ft_rxf_n),
        .i_ft_txe_n   (ft_txe_n),
        .o_ft_rd_n    (ft_rd_n),
        .o_ft_wr_n    (ft_wr_n),
        .o_rx_req     (rx_req),
        .o_rx_data    (rx_data),
        .i_rx_ack     (rx_ack),
        .i_tx_req     (tx_req),
        .i_tx_data    (tx_data),
        .o_tx_ack     (tx_ack)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte number index of the data stream, rebuilt from the seed every time
    function automatic ft_byte_t ref_byte(input int index);
        logic [31:0] s;
        s = SEED;
        for (int i = 0; i <= index; i++) begin
            s = lcg_next(s);
        end
        return s[23:16];
    endfunction

    task automatic check_byte(input ft_byte_t expected, input ft_byte_t actual,
                              input string where);
        if (expected !== actual) begin
            $display("CHECK FAILED at %0t: %s expected %02h got %02h",
                     $time, where, expected, actual);
            byte_errors++;
        end
    endtask

    task automatic check_pulse(input int expected, input int actual, input string which);
        if (expected != actual) begin
            $display("CHECK FAILED at %0t: %s low for %0d cycles, expected %0d",
                     $time, which, actual, expected);
            pulse_errors++;
        end
    endtask

    task automatic check_level(input logic expected, input logic actual, input string what);
        if (expected !== actual) begin
            $display("CHECK FAILED at %0t: %s expected %b got %b",
                     $time, what, expected, actual);
            level_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t: %s", $time, what);
        other_errors++;
    endtask

    task automatic push_host_bytes(input int n);
        for (int i = 0; i < n; i++) begin
            host_q.push_back(ref_byte(rx_pushed));
            rx_pushed++;
        end
    endtask

    task automatic send_tx_byte();
        int gap;
        tx_rnd = lcg_next(tx_rnd);
        gap = tx_rnd[18:16];
        repeat (gap) @(posedge clk);
        tx_data <= ref_byte(TX_BASE + tx_sent);
        tx_req  <= 1'b1;
        tx_sent++;
        @(posedge clk);
        while (!tx_ack) @(posedge clk);
        tx_req  <= 1'b0;
        tx_data <= ~tx_data;
        @(posedge clk);
        while (tx_ack) @(posedge clk);
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Chip model for the read side puts the head byte on the bus while RD# is low
    always @(posedge clk) begin
        if (!ft_rd_n) begin
            rd_was_low = 1'b1;
            if (host_q.size() > 0) begin
                ft_data_in <= host_q[0];
            end
        end else if (rd_was_low) begin
            rd_was_low = 1'b0;
            ft_data_in <= ~ft_data_in;
            if (host_q.size() > 0) begin
                void'(host_q.pop_front());
            end
        end
        ft_rxf_n <= (host_q.size() == 0);
    end

    initial begin : txe_model
        logic [31:0] s;
        int left;
        s = SEED ^ 32'h3;
        left = 0;
        forever begin
            @(posedge clk);
            if (txe_hold_high) begin
                ft_txe_n <= 1'b1;
            end else if (left > 0) begin
                left--;
            end else begin
                s = lcg_next(s);
                if (ft_txe_n) begin
                    ft_txe_n <= 1'b0;
                    left = 8 + s[20:16];
                end else begin
                    ft_txe_n <= 1'b1;
                    left = 1 + s[18:16];
                end
            end
        end
    end

    // Pulse lengths, WR# capture and the order of bus cycles
    always @(posedge clk) begin
        if (rst_n) begin
            if (!ft_rd_n) begin
                rd_len++;
            end else if (rd_len > 0) begin
                check_pulse(P_PULSE, rd_len, "RD#");
                rd_pulses++;
                if (last_dir != 1'b0) begin
                    dir_switches++;
                end
                last_dir = 1'b0;
                rd_len = 0;
            end
            if (!ft_wr_n) begin
                wr_len++;
            end else if (wr_len > 0) begin
                check_pulse(P_PULSE, wr_len, "WR#");
                check_byte(ref_byte(TX_BASE + wr_count), ft_data_out, "WR# capture");
                wr_count++;
                wr_pulses++;
                if (last_dir != 1'b1) begin
                    dir_switches++;
                end
                last_dir = 1'b1;
                wr_len = 0;
            end
        end
    end

    initial begin : rx_agent
        logic [31:0] s;
        int gap;
        s = SEED ^ 32'h2;
        forever begin
            @(posedge clk);
            if (rx_req && !rx_hold) begin
                s = lcg_next(s);
                gap = s[18:16];
                repeat (gap) @(posedge clk);
                check_byte(ref_byte(rx_count), rx_data, "rx port");
                rx_count++;
                rx_ack <= 1'b1;
                @(posedge clk);
                while (rx_req) @(posedge clk);
                rx_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the bridge stopped moving data", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        int snap;
        int total;
        rst_n      = 1'b0;
        ft_data_in = '0;
        ft_rxf_n   = 1'b1;
        ft_txe_n   = 1'b1;
        rx_ack     = 1'b0;
        tx_req     = 1'b0;
        tx_data    = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_level(1'b1, ft_rd_n, "RD# after reset");
        check_level(1'b1, ft_wr_n, "WR# after reset");
        check_level(1'b0, ft_data_oe, "oe after reset");
        check_level(1'b0, rx_req, "o_rx_req after reset");
        check_level(1'b0, tx_ack, "o_tx_ack after reset");

        push_host_bytes(64);
        while (rx_count < rx_pushed) @(posedge clk);

        repeat (64) send_tx_byte();
        while (wr_count < tx_sent) @(posedge clk);

        // The user holds the first byte to create receive back-pressure
        rx_hold = 1'b1;
        push_host_bytes(4);
        while (!rx_req) @(posedge clk);
        snap = rd_pulses;
        repeat (50) @(posedge clk);
        if (rd_pulses != snap) begin
            report_problem("RD# pulse while the rx byte was still held");
        end
        check_level(1'b1, rx_req, "o_rx_req while held");
        if (host_q.size() != 3) begin
            report_problem("chip queue lost bytes while the rx side was stalled");
        end
        rx_hold = 1'b0;
        while (rx_count < rx_pushed) @(posedge clk);

        // Transmit back-pressure with TXE# high
        txe_hold_high = 1'b1;
        repeat (6) @(posedge clk);
        snap = wr_pulses;
        send_tx_byte();
        tx_data <= ref_byte(TX_BASE + tx_sent);
        tx_req  <= 1'b1;
        tx_sent++;
        repeat (50) begin
            @(posedge clk);
            check_level(1'b0, tx_ack, "o_tx_ack for a second byte with TXE# high");
        end
        if (wr_pulses != snap) begin
            report_problem("WR# pulse while TXE# was high");
        end
        txe_hold_high = 1'b0;
        while (!tx_ack) @(posedge clk);
        tx_req  <= 1'b0;
        tx_data <= ~tx_data;
        @(posedge clk);
        while (tx_ack) @(posedge clk);
        while (wr_count < tx_sent) @(posedge clk);

        // Both directions at once
        snap = dir_switches;
        fork
            push_host_bytes(64);
            repeat (64) send_tx_byte();
        join
        while (rx_count < rx_pushed || wr_count < tx_sent) @(posedge clk);
        if (dir_switches - snap < 16) begin
            report_problem("reads and writes did not interleave under simultaneous traffic");
        end

        repeat (20) @(posedge clk);
        if (host_q.size() != 0 || rx_count != rx_pushed || wr_count != tx_sent) begin
            report_problem("byte counts differ at the end of the run");
        end

        total = byte_errors + pulse_errors + level_errors + other_errors
              + u_dut.u_assertions.fail_count;
        $display("Errors: byte %0d, pulse %0d, level %0d, other %0d, assertion %0d",
                 byte_errors, pulse_errors, level_errors, other_errors,
                 u_dut.u_assertions.fail_count);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/ft245_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module ft245_bridge #(
    parameter int P_PULSE_CYCLES = ft245_pkg::FT_PULSE_DEFAULT
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // FT232H pins, data bus split into in, out and enable
    input  ft245_pkg::ft_byte_t i_ft_data,
    output ft245_pkg::ft_byte_t o_ft_data,
    output logic                o_ft_data_oe,
    input  logic                i_ft_rxf_n,
    input  logic                i_ft_txe_n,
    output logic                o_ft_rd_n,
    output logic                o_ft_wr_n,
    // User receive side
    output logic                o_rx_req,
    output ft245_pkg::ft_byte_t o_rx_data,
    input  logic                i_rx_ack,
    // User transmit side
    input  logic                i_tx_req,
    input  ft245_pkg::ft_byte_t i_tx_data,
    output logic                o_tx_ack
);
    import ft245_pkg::*;

    logic     rx_full;
    logic     rx_load;
    ft_byte_t rx_load_data;
    logic     tx_full;
    logic     tx_take;
    ft_byte_t tx_held_data;

    ft_cycle_if rd ();
    ft_cycle_if wr ();

    ft245_bus_ctrl u_bus_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ft_rxf_n (i_ft_rxf_n),
        .i_ft_txe_n (i_ft_txe_n),
        .i_rx_full  (rx_full),
        .o_rx_load  (rx_load),
        .o_rx_data  (rx_load_data),
        .i_tx_full  (tx_full),
        .i_tx_data  (tx_held_data),
        .o_tx_take  (tx_take),
        .rd         (rd.ctrl),
        .wr         (wr.ctrl)
    );

    ft245_read_engine #(
        .P_PULSE_CYCLES (P_PULSE_CYCLES)
    ) u_read_engine (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_ft_data (i_ft_data),
        .o_ft_rd_n (o_ft_rd_n),
        .cyc       (rd.engine)
    );

    ft245_write_engine #(
        .P_PULSE_CYCLES (P_PULSE_CYCLES)
    ) u_write_engine (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_ft_data    (o_ft_data),
        .o_ft_data_oe (o_ft_data_oe),
        .o_ft_wr_n    (o_ft_wr_n),
        .cyc          (wr.engine)
    );

    ft245_rx_port u_rx_port (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_load    (rx_load),
        .i_data    (rx_load_data),
        .o_full    (rx_full),
        .o_rx_req  (o_rx_req),
        .o_rx_data (o_rx_data),
        .i_rx_ack  (i_rx_ack)
    );

    ft245_tx_port u_tx_port (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_tx_req  (i_tx_req),
        .i_tx_data (i_tx_data),
        .o_tx_ack  (o_tx_ack),
        .o_full    (tx_full),
        .o_data    (tx_held_data),
        .i_take    (tx_take)
    );

endmodule

`default_nettype wire

/* rtl/ft245_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ft245_bus_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_ft_rxf_n,
    input  logic                i_ft_txe_n,
    input  logic                i_rx_full,
    output logic                o_rx_load,
    output ft245_pkg::ft_byte_t o_rx_data,
    input  logic                i_tx_full,
    input  ft245_pkg::ft_byte_t i_tx_data,
    output logic                o_tx_take,
    ft_cycle_if.ctrl            rd,
    ft_cycle_if.ctrl            wr
);
    import ft245_pkg::*;

    logic [1:0]    rxf_sync;
    logic [1:0]    txe_sync;
    logic          rxf_n_s;
    logic          txe_n_s;
    logic          can_rd;
    logic          can_wr;
    logic          start_rd;
    logic          start_wr;
    logic          last_wr_q;
    logic          rd_req_q;
    logic          wr_req_q;
    ft_byte_t      wr_data_q;
    ft_arb_state_e state;

    // Both flags are asynchronous to i_clk and idle high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rxf_sync <= 2'b11;
            txe_sync <= 2'b11;
        end else begin
            rxf_sync <= {rxf_sync[0], i_ft_rxf_n};
            txe_sync <= {txe_sync[0], i_ft_txe_n};
        end
    end

    assign rxf_n_s = rxf_sync[1];
    assign txe_n_s = txe_sync[1];

    assign can_rd = !rxf_n_s && !i_rx_full;
    assign can_wr = !txe_n_s && i_tx_full;

    // With both directions ready, serve the one that waited last time
    assign start_rd = (state == ARB_IDLE) && can_rd && (!can_wr || last_wr_q);
    assign start_wr = (state == ARB_IDLE) && can_wr && !start_rd;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ARB_IDLE;
            rd_req_q  <= 1'b0;
            wr_req_q  <= 1'b0;
            last_wr_q <= 1'b1;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (start_rd) begin
                        state     <= ARB_READ;
                        rd_req_q  <= 1'b1;
                        last_wr_q <= 1'b0;
                    end else if (start_wr) begin
                        state     <= ARB_WRITE;
                        wr_req_q  <= 1'b1;
                        last_wr_q <= 1'b1;
                    end
                end
                ARB_READ: begin
                    if (rd_req_q && rd.ack) begin
                        rd_req_q <= 1'b0;
                    end else if (!rd_req_q && !rd.ack) begin
                        state <= ARB_TURN;
                    end
                end
                ARB_WRITE: begin
                    if (wr_req_q && wr.ack) begin
                        wr_req_q <= 1'b0;
                    end else if (!wr_req_q && !wr.ack) begin
                        state <= ARB_TURN;
                    end
                end
                ARB_TURN: begin
                    state <= ARB_IDLE;
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (start_wr) begin
            wr_data_q <= i_tx_data;
        end
    end

    // The completing ack moves the byte between the engine and the user port
    assign o_rx_load = (state == ARB_READ) && rd_req_q && rd.ack;
    assign o_rx_data = rd.rdata;
    assign o_tx_take = (state == ARB_WRITE) && wr_req_q && wr.ack;

    assign rd.req   = rd_req_q;
    assign rd.wdata = '0;
    assign wr.req   = wr_req_q;
    assign wr.wdata = wr_data_q;

endmodule

`default_nettype wire

/* rtl/ft245_pkg.sv */
`default_nettype none

package ft245_pkg;

    // One byte of the FT232H data bus
    typedef logic [7:0] ft_byte_t;

    // States of the read/write arbiter in the bus control block
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_READ  = 2'd1,
        ARB_WRITE = 2'd2,
        ARB_TURN  = 2'd3
    } ft_arb_state_e;

    // RD# and WR# low time in clock cycles, must be 2 or more
    localparam int FT_PULSE_DEFAULT = 3;

endpackage

`default_nettype wire

/* rtl/ft245_read_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module ft245_read_engine #(
    parameter int P_PULSE_CYCLES = ft245_pkg::FT_PULSE_DEFAULT
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  ft245_pkg::ft_byte_t i_ft_data,
    output logic                o_ft_rd_n,
    ft_cycle_if.engine          cyc
);
    import ft245_pkg::*;

    localparam int CNT_W = $clog2(P_PULSE_CYCLES + 1);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_LOW,
        RD_ACK
    } rd_state_e;

    rd_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic             rd_n_q;
    logic             ack_q;
    ft_byte_t         rdata_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= RD_IDLE;
            cnt    <= '0;
            rd_n_q <= 1'b1;
            ack_q  <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (cyc.req) begin
                        state  <= RD_LOW;
                        rd_n_q <= 1'b0;
                        cnt    <= CNT_W'(P_PULSE_CYCLES - 1);
                    end
                end
                RD_LOW: begin
                    // Last low cycle, the chip has had the full pulse to drive data
                    if (cnt == '0) begin
                        state  <= RD_ACK;
                        rd_n_q <= 1'b1;
                        ack_q  <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RD_ACK: begin
                    if (!cyc.req) begin
                        state <= RD_IDLE;
                        ack_q <= 1'b0;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RD_LOW && cnt == '0) begin
            rdata_q <= i_ft_data;
        end
    end

    assign o_ft_rd_n = rd_n_q;
    assign cyc.ack   = ack_q;
    assign cyc.rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/ft245_rx_port.sv */
`timescale 1ns/1ps
`default_nettype none

module ft245_rx_port (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_load,
    input  ft245_pkg::ft_byte_t i_data,
    output logic                o_full,
    output logic                o_rx_req,
    output ft245_pkg::ft_byte_t o_rx_data,
    input  logic                i_rx_ack
);
    import ft245_pkg::*;

    logic     full_q;
    logic     req_q;
    ft_byte_t data_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            full_q <= 1'b0;
            req_q  <= 1'b0;
        end else begin
            if (i_load && !full_q) begin
                full_q <= 1'b1;
                req_q  <= 1'b1;
            end else if (req_q && i_rx_ack) begin
                req_q <= 1'b0;
            end else if (full_q && !req_q && !i_rx_ack) begin
                // Handshake finished, the slot can take the next byte
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load && !full_q) begin
            data_q <= i_data;
        end
    end

    assign o_full    = full_q;
    assign o_rx_req  = req_q;
    assign o_rx_data = data_q;

endmodule

`default_nettype wire

/* rtl/ft245_tx_port.sv */
`timescale 1ns/1ps
`default_nettype none

module ft245_tx_port (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_tx_req,
    input  ft245_pkg::ft_byte_t i_tx_data,
    output logic                o_tx_ack,
    output logic                o_full,
    output ft245_pkg::ft_byte_t o_data,
    input  logic                i_take
);
    import ft245_pkg::*;

    logic     full_q;
    logic     ack_q;
    logic     accept;
    ft_byte_t data_q;

    // A new byte only when the slot is free and the previous handshake closed
    assign accept = i_tx_req && !full_q && !ack_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            full_q <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            if (accept) begin
                full_q <= 1'b1;
                ack_q  <= 1'b1;
            end else begin
                if (ack_q && !i_tx_req) begin
                    ack_q <= 1'b0;
                end
                if (full_q && i_take) begin
                    full_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            data_q <= i_tx_data;
        end
    end

    assign o_tx_ack = ack_q;
    assign o_full   = full_q;
    assign o_data   = data_q;

endmodule

`default_nettype wire

/* rtl/ft245_write_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module ft245_write_engine #(
    parameter int P_PULSE_CYCLES = ft245_pkg::FT_PULSE_DEFAULT
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    output ft245_pkg::ft_byte_t o_ft_data,
    output logic                o_ft_data_oe,
    output logic                o_ft_wr_n,
    ft_cycle_if.engine          cyc
);
    import ft245_pkg::*;

    localparam int CNT_W = $clog2(P_PULSE_CYCLES + 1);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_SETUP,
        WR_PULSE,
        WR_HOLD,
        WR_DONE
    } wr_state_e;

    wr_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic             oe_q;
    logic             wr_n_q;
    logic             ack_q;
    ft_byte_t         data_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= WR_IDLE;
            cnt    <= '0;
            oe_q   <= 1'b0;
            wr_n_q <= 1'b1;
            ack_q  <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (cyc.req) begin
                        state <= WR_SETUP;
                        oe_q  <= 1'b1;
                    end
                end
                // Data has been on the bus for one cycle before WR# falls
                WR_SETUP: begin
                    state  <= WR_PULSE;
                    wr_n_q <= 1'b0;
                    cnt    <= CNT_W'(P_PULSE_CYCLES - 1);
                end
                WR_PULSE: begin
                    if (cnt == '0) begin
                        state  <= WR_HOLD;
                        wr_n_q <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                // The chip latches on the rising edge of WR#, keep the bus one more cycle
                WR_HOLD: begin
                    state <= WR_DONE;
                    oe_q  <= 1'b0;
                    ack_q <= 1'b1;
                end
                WR_DONE: begin
                    if (!cyc.req) begin
                        state <= WR_IDLE;
                        ack_q <= 1'b0;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == WR_IDLE && cyc.req) begin
            data_q <= cyc.wdata;
        end
    end

    assign o_ft_data    = data_q;
    assign o_ft_data_oe = oe_q;
    assign o_ft_wr_n    = wr_n_q;
    assign cyc.ack      = ack_q;
    assign cyc.rdata    = data_q;

endmodule

`default_nettype wire

/* rtl/ft_cycle_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ft_cycle_if;
    import ft245_pkg::*;

    // Four-phase request of one bus cycle from control to an engine
    logic     req;
    logic     ack;
    ft_byte_t wdata;
    ft_byte_t rdata;

    modport ctrl (
        output req,
        output wdata,
        input  ack,
        input  rdata
    );

    modport engine (
        input  req,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire
